/* Makefile */
VERILATOR ?= verilator
FLAGS     = --binary --timing --assert
TOP       = xaui_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
source/xaui_pkg.sv
source/credit_fifo.sv
source/tx_frame_arbiter.sv
source/xgmii_tx_framer.sv
source/xgmii_rx_deframer.sv
source/xaui_transfer_top.sv
tb/tb_clock.sv
tb/xaui_tb.sv

/* source/credit_fifo.sv */
/*
 * Credit FIFO. Show-ahead circular buffer for any payload type, which
 * returns one credit pulse per popped entry.
 */
`timescale 1ns/1ps

module credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 16
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     full,
  output logic     credit
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;

  // pointers wrap at depth, which need not be a power of two.
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count  <= count + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop);
      // the space freed by a pop goes back to the producer next cycle.
      credit <= pop;
    end
  end

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);
  assign full      = (count == (ptr_w + 1)'(depth));

  // a producer that respects its credits never finds the queue full.
  a_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("credit_fifo: push while full");

  a_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> not_empty)
    else $error("credit_fifo: pop while empty");

endmodule

/* source/tx_frame_arbiter.sv */
/*
 * Transmit frame arbiter. Counts complete frames per channel and hands
 * the framer to one channel per frame, round-robin.
 */
`timescale 1ns/1ps

module tx_frame_arbiter import xaui_pkg::*; #(
  parameter int channel_count = 2
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [channel_count-1:0]           push,
  input  logic [channel_count-1:0]           push_last,
  input  logic                               ready,
  input  logic                               pop,
  input  frame_word_t                        heads [channel_count],
  output logic                               grant_valid,
  output logic [$clog2(channel_count)-1:0]   grant_channel,
  output logic [channel_count-1:0]           channel_pop,
  output frame_word_t                        head
);

  localparam int sel_w   = $clog2(channel_count);
  // wide enough for a frame count up to any practical queue depth.
  localparam int count_w = 8;

  logic [count_w-1:0] frame_count [channel_count];
  logic [sel_w-1:0]   pick;
  logic               found;

  assign head = heads[grant_channel];

  for (genvar c = 0; c < channel_count; c++) begin : g_chan
    assign channel_pop[c] = pop && grant_valid && (grant_channel == sel_w'(c));

    always_ff @(posedge clk) begin
      if (reset) begin
        frame_count[c] <= '0;
      end else begin
        frame_count[c] <= frame_count[c] + count_w'(push[c] && push_last[c])
                        - count_w'(channel_pop[c] && head.last);
      end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
      (channel_pop[c] && head.last) |-> (frame_count[c] != '0))
      else $error("tx_frame_arbiter: frame count underflow on channel %0d", c);
  end

  // search starts one past the previous winner, which grant_channel still holds.
  always_comb begin
    int idx;
    pick  = grant_channel;
    found = 1'b0;
    for (int i = 1; i <= channel_count; i++) begin
      idx = (int'(grant_channel) + i) % channel_count;
      if (!found && frame_count[idx] != '0) begin
        found = 1'b1;
        pick  = sel_w'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      grant_valid   <= 1'b0;
      grant_channel <= sel_w'(channel_count - 1);
    end else if (grant_valid) begin
      if (pop && head.last) begin
        grant_valid <= 1'b0;
      end
    end else if (ready && found) begin
      grant_valid   <= 1'b1;
      grant_channel <= pick;
    end
  end

endmodule

/* source/xaui_pkg.sv */
/*
 * XGMII transfer package. Control characters, fixed columns and the
 * column and word structs shared by the transmit and receive paths.
 */
package xaui_pkg;

  // ####################
  // control characters
  // ####################

  localparam logic [7:0] xgmii_idle  = 8'h07;
  localparam logic [7:0] xgmii_start = 8'hfb;
  localparam logic [7:0] xgmii_term  = 8'hfd;
  localparam logic [7:0] xgmii_error = 8'hfe;

  // ####################
  // whole columns
  // ####################

  // eight idle characters, sent with all control bits set.
  localparam logic [63:0] idle_column = {8{xgmii_idle}};

  // local fault is a sequence ordered set in lane 0 and again in lane 4.
  localparam logic [63:0] fault_column = 64'h0100009c_0100009c;

  // number of user transmit channels sharing the framer.
  localparam int channel_count = 2;

  // ####################
  // structs
  // ####################

  // one XGMII column, lane 0 in the low byte and its control bit in ctrl[0].
  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  ctrl;
  } xg_column_t;

  // one user word; last closes the frame.
  typedef struct packed {
    logic [63:0] data;
    logic        last;
  } frame_word_t;

endpackage

/* source/xaui_transfer_top.sv */
/*
 * XGMII transfer top. Two credited transmit queues feed the framer
 * through the arbiter; the deframer fills a credited receive queue.
 */
`timescale 1ns/1ps

module xaui_transfer_top import xaui_pkg::*; #(
  parameter int tx_depth = 16,
  parameter int rx_depth = 32
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [channel_count-1:0] tx_push,
  input  frame_word_t              tx_word [channel_count],
  input  xg_column_t               xgmii_rx,
  input  logic                     rx_credit,
  output logic [channel_count-1:0] tx_credit,
  output xg_column_t               xgmii_tx,
  output logic                     rx_valid,
  output frame_word_t              rx_word,
  output logic                     link_fault,
  output logic                     rx_overflow
);

  // the sink may grant credits ahead of the data.
  localparam int credit_w = 16;

  frame_word_t                      tx_heads [channel_count];
  frame_word_t                      tx_head;
  logic [channel_count-1:0]         tx_last, channel_pop;
  logic                             grant_valid, framer_ready, framer_pop;
  frame_word_t                      rx_entry, rx_head;
  logic                             rx_wr_en, rx_full, rx_not_empty, rx_pop;
  logic [credit_w-1:0]              rx_credits;

  // ####################
  // transmit path
  // ####################

  for (genvar c = 0; c < channel_count; c++) begin : g_tx
    assign tx_last[c] = tx_word[c].last;

    credit_fifo #(.payload_t(frame_word_t), .depth(tx_depth)) u_tx_fifo (
      .clk(clk), .reset(reset), .push(tx_push[c]), .push_data(tx_word[c]),
      .pop(channel_pop[c]), .head(tx_heads[c]), .not_empty(), .full(),
      .credit(tx_credit[c]));
  end

  tx_frame_arbiter #(.channel_count(channel_count)) u_arbiter (
    .clk(clk), .reset(reset), .push(tx_push), .push_last(tx_last),
    .ready(framer_ready), .pop(framer_pop), .heads(tx_heads),
    .grant_valid(grant_valid), .grant_channel(),
    .channel_pop(channel_pop), .head(tx_head));

  xgmii_tx_framer u_framer (
    .clk(clk), .reset(reset), .grant_valid(grant_valid), .head(tx_head),
    .ready(framer_ready), .pop(framer_pop), .xgmii_tx(xgmii_tx));

  // ####################
  // receive path
  // ####################

  xgmii_rx_deframer u_deframer (
    .clk(clk), .reset(reset), .xgmii_rx(xgmii_rx), .full(rx_full),
    .wr_en(rx_wr_en), .wr_word(rx_entry), .link_fault(link_fault),
    .rx_overflow(rx_overflow));

  // the queue's own credit pulse lines up with the registered word.
  credit_fifo #(.payload_t(frame_word_t), .depth(rx_depth)) u_rx_fifo (
    .clk(clk), .reset(reset), .push(rx_wr_en), .push_data(rx_entry),
    .pop(rx_pop), .head(rx_head), .not_empty(rx_not_empty), .full(rx_full),
    .credit(rx_valid));

  assign rx_pop = rx_not_empty && (rx_credits != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_credits <= '0;
    end else begin
      rx_credits <= rx_credits + credit_w'(rx_credit) - credit_w'(rx_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (rx_pop) begin
      rx_word <= rx_head;
    end
  end

endmodule

/* source/xgmii_rx_deframer.sv */
/*
 * XGMII receive deframer. Finds frames that start in lane 0 or lane 4,
 * rebuilds whole words, marks the last one and flags local faults.
 */
`timescale 1ns/1ps

module xgmii_rx_deframer import xaui_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  xg_column_t  xgmii_rx,
  input  logic        full,
  output logic        wr_en,
  output frame_word_t wr_word,
  output logic        link_fault,
  output logic        rx_overflow
);

  typedef enum logic {
    rx_idle,
    rx_frame
  } rx_state_t;

  rx_state_t   state;
  logic        lane4;
  logic [31:0] leftover;
  logic        have_left;
  logic [63:0] pending;
  logic        pending_valid;
  logic        entry_valid;
  frame_word_t entry;

  logic        start0, start4, term0, term4, data_col;
  logic        take_word, load_pending, load_left, frame_end;
  frame_word_t next_entry;

  assign start0   = xgmii_rx.ctrl[0] && (xgmii_rx.data[7:0] == xgmii_start);
  assign start4   = xgmii_rx.ctrl[4] && (xgmii_rx.data[39:32] == xgmii_start);
  assign term0    = xgmii_rx.ctrl[0] && (xgmii_rx.data[7:0] == xgmii_term);
  assign term4    = xgmii_rx.ctrl[4] && (xgmii_rx.data[39:32] == xgmii_term);
  assign data_col = (xgmii_rx.ctrl == 8'h00);

  // ####################
  // word assembly
  // ####################

  // other control columns inside a frame are skipped.
  always_comb begin
    take_word    = 1'b0;
    load_pending = 1'b0;
    load_left    = 1'b0;
    frame_end    = 1'b0;
    next_entry   = '{data: pending, last: 1'b0};
    if (state == rx_frame) begin
      if (!lane4) begin
        // one word is held back until we know whether terminate follows.
        if (term0) begin
          frame_end       = 1'b1;
          take_word       = pending_valid;
          next_entry.last = 1'b1;
        end else if (data_col) begin
          take_word    = pending_valid;
          load_pending = 1'b1;
        end
      end else begin
        next_entry.data = {xgmii_rx.data[31:0], leftover};
        if (term4) begin
          frame_end       = 1'b1;
          take_word       = have_left;
          next_entry.last = 1'b1;
        end else if (data_col) begin
          // the first data column only finishes the preamble.
          take_word = have_left;
          load_left = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= rx_idle;
      lane4         <= 1'b0;
      have_left     <= 1'b0;
      pending_valid <= 1'b0;
      entry_valid   <= 1'b0;
      link_fault    <= 1'b0;
    end else begin
      entry_valid <= take_word;
      link_fault  <= (xgmii_rx.data == fault_column);
      case (state)
        rx_idle: begin
          have_left     <= 1'b0;
          pending_valid <= 1'b0;
          if (start0 || start4) begin
            state <= rx_frame;
            lane4 <= !start0;
          end
        end
        rx_frame: begin
          if (frame_end) begin
            state <= rx_idle;
          end
          if (load_pending) begin
            pending_valid <= 1'b1;
          end
          if (load_left) begin
            have_left <= 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_word) entry <= next_entry;
    if (load_pending) pending <= xgmii_rx.data;
    if (load_left) leftover <= xgmii_rx.data[63:32];
  end

  // the line cannot wait, so a word meeting a full queue is lost.
  assign wr_en       = entry_valid && !full;
  assign rx_overflow = entry_valid && full;
  assign wr_word     = entry;

endmodule

/* source/xgmii_tx_framer.sv */
/*
 * XGMII transmit framer. Wraps each granted frame in a start and a
 * terminate column and fills the gaps with idle columns.
 */
`timescale 1ns/1ps

module xgmii_tx_framer import xaui_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        grant_valid,
  input  frame_word_t head,
  output logic        ready,
  output logic        pop,
  output xg_column_t  xgmii_tx
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_term
  } tx_state_t;

  tx_state_t state;

  assign ready = (state == st_idle);
  // the queue head moves on in the same cycle its word is registered.
  assign pop   = (state == st_data);

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= st_idle;
      xgmii_tx.data <= idle_column;
      xgmii_tx.ctrl <= 8'hff;
    end else begin
      case (state)
        st_idle: begin
          xgmii_tx.data <= idle_column;
          xgmii_tx.ctrl <= 8'hff;
          if (grant_valid) begin
            state <= st_start;
          end
        end
        st_start: begin
          xgmii_tx.data <= {{7{xgmii_error}}, xgmii_start};
          xgmii_tx.ctrl <= 8'hff;
          state         <= st_data;
        end
        st_data: begin
          xgmii_tx.data <= head.data;
          xgmii_tx.ctrl <= 8'h00;
          if (head.last) begin
            state <= st_term;
          end
        end
        st_term: begin
          xgmii_tx.data <= {{7{xgmii_idle}}, xgmii_term};
          xgmii_tx.ctrl <= 8'hff;
          state         <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // the arbiter keeps its grant until the last word of the frame has gone.
  a_data_granted: assert property (@(posedge clk) disable iff (reset)
    (state == st_data) |-> grant_valid)
    else $error("xgmii_tx_framer: data column without a grant");

endmodule

/* tb/tb_clock.sv */
/*
 * Testbench clock. Makes a 10 ns clock and holds reset high for the
 * first cycles.
 */
`timescale 1ns/1ps

module tb_clock #(
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* tb/xaui_tb.sv */
/*
 * XGMII transfer testbench. Drives transmit frames on both channels and
 * receive frames in both alignments, and checks every column and word.
 */
`timescale 1ns/1ps

module xaui_tb import xaui_pkg::*; ();

  localparam int tx_depth   = 16;
  localparam int rx_depth   = 32;
  localparam int wait_limit = 4000;

  logic                     clk;
  logic                     reset;
  logic [channel_count-1:0] tx_push;
  frame_word_t              tx_word [channel_count];
  xg_column_t               xgmii_rx;
  logic                     rx_credit;
  logic [channel_count-1:0] tx_credit;
  xg_column_t               xgmii_tx;
  logic                     rx_valid;
  frame_word_t              rx_word;
  logic                     link_fault;
  logic                     rx_overflow;

  int          errors;
  int          timeouts;
  int          fault_count;
  int          overflow_count;
  int          rx_granted;
  int          rx_delivered;
  int          tx_credits [channel_count];
  logic [31:0] seed;
  logic        prev_idle;
  xg_column_t  tx_exp [$];
  frame_word_t rx_exp [$];
  frame_word_t q0 [$];
  frame_word_t q1 [$];
  logic [63:0] words [$];
  xg_column_t  rx_cols [$];

  tb_clock u_clock (.clk(clk), .reset(reset));

  xaui_transfer_top #(.tx_depth(tx_depth), .rx_depth(rx_depth)) DUT (
    .clk(clk), .reset(reset), .tx_push(tx_push), .tx_word(tx_word),
    .xgmii_rx(xgmii_rx), .rx_credit(rx_credit), .tx_credit(tx_credit),
    .xgmii_tx(xgmii_tx), .rx_valid(rx_valid), .rx_word(rx_word),
    .link_fault(link_fault), .rx_overflow(rx_overflow));

  // ####################
  // reference model
  // ####################

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    seed = lcg_next(seed);
    return seed;
  endfunction

  function automatic void make_words(input int n);
    words.delete();
    for (int i = 0; i < n; i++) begin
      words.push_back({rand32(), rand32()});
    end
  endfunction

  // queues the words on one channel and the columns the framer must send.
  function automatic void queue_tx_frame(input int ch);
    frame_word_t fw;
    tx_exp.push_back(xg_column_t'{data: {{7{xgmii_error}}, xgmii_start}, ctrl: 8'hff});
    for (int i = 0; i < words.size(); i++) begin
      fw = frame_word_t'{data: words[i], last: (i == words.size() - 1)};
      if (ch == 0) begin
        q0.push_back(fw);
      end else begin
        q1.push_back(fw);
      end
      tx_exp.push_back(xg_column_t'{data: words[i], ctrl: 8'h00});
    end
    tx_exp.push_back(xg_column_t'{data: {{7{xgmii_idle}}, xgmii_term}, ctrl: 8'hff});
  endfunction

  // line columns of one receive frame that starts in lane 0 or lane 4.
  function automatic void rx_frame_columns(input logic lane4);
    int n;
    n = words.size();
    if (!lane4) begin
      rx_cols.push_back(xg_column_t'{data: {8'hd5, {6{8'h55}}, xgmii_start}, ctrl: 8'h01});
      for (int i = 0; i < n; i++) begin
        rx_cols.push_back(xg_column_t'{data: words[i], ctrl: 8'h00});
      end
      rx_cols.push_back(xg_column_t'{data: {{7{xgmii_idle}}, xgmii_term}, ctrl: 8'hff});
    end else begin
      rx_cols.push_back(xg_column_t'{data: {{3{8'h55}}, xgmii_start, {4{xgmii_idle}}},
                                     ctrl: 8'h1f});
      rx_cols.push_back(xg_column_t'{data: {words[0][31:0], 8'hd5, {3{8'h55}}},
                                     ctrl: 8'h00});
      for (int i = 1; i < n; i++) begin
        rx_cols.push_back(xg_column_t'{data: {words[i][31:0], words[i-1][63:32]},
                                       ctrl: 8'h00});
      end
      rx_cols.push_back(xg_column_t'{data: {{3{xgmii_idle}}, xgmii_term, words[n-1][63:32]},
                                     ctrl: 8'hf0});
    end
  endfunction

  // only the first keep words reach the sink; last marks the frame's end.
  function automatic void expect_rx_words(input int keep);
    for (int i = 0; i < words.size() && i < keep; i++) begin
      rx_exp.push_back(frame_word_t'{data: words[i], last: (i == words.size() - 1)});
    end
  endfunction

  // ####################
  // checks and report
  // ####################

  task automatic check(input string what, input logic [71:0] got, input logic [71:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string msg);
    timeouts++;
    $display("timeout: %s", msg);
  endtask

  always @(posedge clk) begin
    if (!reset) begin
      if (xgmii_tx.data == idle_column && xgmii_tx.ctrl == 8'hff) begin
        prev_idle = 1'b1;
      end else begin
        if (tx_exp.size() == 0) begin
          errors++;
          $display("unexpected transmit column %h at %0t", xgmii_tx, $time);
        end else begin
          if (xgmii_tx.ctrl == 8'hff && xgmii_tx.data[7:0] == xgmii_start && !prev_idle) begin
            errors++;
            $display("start column at %0t follows no idle column", $time);
          end
          check("transmit column", xgmii_tx, tx_exp.pop_front());
        end
        prev_idle = 1'b0;
      end
      if (rx_valid) begin
        rx_delivered++;
        if (rx_delivered > rx_granted) begin
          errors++;
          $display("receive word at %0t was delivered without a credit", $time);
        end
        if (rx_exp.size() == 0) begin
          errors++;
          $display("unexpected receive word %h at %0t", rx_word, $time);
        end else begin
          check("receive word", 72'(rx_word), 72'(rx_exp.pop_front()));
        end
      end
      if (rx_credit) begin
        rx_granted++;
      end
      for (int c = 0; c < channel_count; c++) begin
        if (tx_credit[c]) begin
          tx_credits[c]++;
          if (tx_credits[c] > tx_depth) begin
            errors++;
            $display("channel %0d returned more credits than it was given", c);
          end
        end
      end
      if (link_fault) begin
        fault_count++;
      end
      if (rx_overflow) begin
        overflow_count++;
      end
    end
  end

  // ####################
  // stimulus
  // ####################

  // both channels push in the same cycles, each while it holds a credit.
  task automatic load_channels();
    int t;
    while (q0.size() > 0 || q1.size() > 0) begin
      @(negedge clk);
      tx_push = '0;
      t = 0;
      while ((q0.size() > 0 && tx_credits[0] == 0) || (q1.size() > 0 && tx_credits[1] == 0)) begin
        t++;
        if (t > wait_limit) begin
          report_timeout("transmit credits never came back");
          q0.delete();
          q1.delete();
          break;
        end
        @(negedge clk);
      end
      if (q0.size() > 0) begin
        tx_word[0] = q0.pop_front();
        tx_push[0] = 1'b1;
        tx_credits[0]--;
      end
      if (q1.size() > 0) begin
        tx_word[1] = q1.pop_front();
        tx_push[1] = 1'b1;
        tx_credits[1]--;
      end
    end
    @(negedge clk);
    tx_push = '0;
  endtask

  task automatic wait_tx_drained();
    int t;
    t = 0;
    while (tx_exp.size() != 0 || tx_credits[0] != tx_depth || tx_credits[1] != tx_depth) begin
      @(negedge clk);
      t++;
      if (t > wait_limit) begin
        report_timeout("transmit frames did not all leave");
        break;
      end
    end
  endtask

  task automatic wait_rx_drained();
    int t;
    t = 0;
    while (rx_exp.size() != 0) begin
      @(negedge clk);
      t++;
      if (t > wait_limit) begin
        report_timeout("receive words did not all arrive");
        break;
      end
    end
  endtask

  task automatic send_rx_columns();
    while (rx_cols.size() > 0) begin
      @(negedge clk);
      xgmii_rx = rx_cols.pop_front();
    end
    @(negedge clk);
    xgmii_rx = xg_column_t'{data: idle_column, ctrl: 8'hff};
  endtask

  task automatic grant_credits(input int n, input int gap);
    repeat (n) begin
      @(negedge clk);
      rx_credit = 1'b1;
      @(negedge clk);
      rx_credit = 1'b0;
      repeat (gap - 1) @(negedge clk);
    end
  endtask

  initial begin
    int t;
    int n;
    int total;
    errors         = 0;
    timeouts       = 0;
    fault_count    = 0;
    overflow_count = 0;
    rx_granted     = 0;
    rx_delivered   = 0;
    seed           = 32'h4b3cbf3d;
    prev_idle      = 1'b1;
    tx_push        = '0;
    tx_word[0]     = '0;
    tx_word[1]     = '0;
    rx_credit      = 1'b0;
    xgmii_rx       = xg_column_t'{data: idle_column, ctrl: 8'hff};
    for (int c = 0; c < channel_count; c++) begin
      tx_credits[c] = tx_depth;
    end

    t = 0;
    while (reset !== 1'b0) begin
      @(negedge clk);
      t++;
      if (t > 100) begin
        report_timeout("reset never went low");
        break;
      end
    end
    repeat (10) @(negedge clk);
    check("transmit bus after reset", xgmii_tx, {idle_column, 8'hff});

    // single channel frames.
    for (int f = 0; f < 4; f++) begin
      n = int'(rand32() % 32'd8) + 1;
      make_words(n);
      queue_tx_frame(0);
    end
    load_channels();
    wait_tx_drained();

    // channel 0 won last, so channel 1 goes first and they alternate.
    for (int f = 0; f < 2; f++) begin
      n = int'(rand32() % 32'd6) + 1;
      make_words(n);
      queue_tx_frame(1);
      make_words(n);
      queue_tx_frame(0);
    end
    load_channels();
    wait_tx_drained();

    // receive frames in both alignments, paced by credits.
    total = 0;
    for (int f = 0; f < 4; f++) begin
      n = int'(rand32() % 32'd8) + 1;
      make_words(n);
      rx_frame_columns(f[0]);
      expect_rx_words(n);
      total += n;
    end
    fork
      send_rx_columns();
      grant_credits(total, 3);
    join
    wait_rx_drained();

    @(negedge clk);
    xgmii_rx = xg_column_t'{data: fault_column, ctrl: 8'h11};
    @(negedge clk);
    xgmii_rx = xg_column_t'{data: idle_column, ctrl: 8'hff};
    t = 0;
    while (fault_count == 0) begin
      @(negedge clk);
      t++;
      if (t > 20) begin
        report_timeout("no link fault after a fault column");
        break;
      end
    end

    // no credits are held, so the queue fills and the tail is dropped.
    make_words(rx_depth + 3);
    rx_frame_columns(1'b0);
    expect_rx_words(rx_depth);
    send_rx_columns();
    t = 0;
    while (overflow_count < 3) begin
      @(negedge clk);
      t++;
      if (t > 100) begin
        report_timeout("receive overflow was never flagged");
        break;
      end
    end
    grant_credits(rx_depth, 1);
    wait_rx_drained();

    repeat (10) @(negedge clk);
    check("link fault pulses", 72'(fault_count), 72'(1));
    check("overflow pulses", 72'(overflow_count), 72'(3));
    finish_run();
  end

endmodule
